//--- verilog/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // clk cycles per 16x oversample tick, sized for simulation.
    localparam int CLKS_PER_TICK = 4;

    // oversample ticks per serial bit.
    localparam int OVERSAMPLE = 16;

    // payload bits in one 8N1 frame.
    localparam int DATA_BITS = 8;

    // start, data and stop bits of a whole frame in clk cycles.
    localparam int CLKS_PER_FRAME = CLKS_PER_TICK * OVERSAMPLE * (DATA_BITS + 2);

endpackage

`default_nettype wire

//--- verilog/uart_types_pkg.sv
`default_nettype none

package uart_types_pkg;

    // one payload byte.
    typedef logic [uart_cfg_pkg::DATA_BITS-1:0] uart_byte_t;

    // position within one bit, in oversample ticks.
    typedef logic [$clog2(uart_cfg_pkg::OVERSAMPLE)-1:0] tick_cnt_t;

    // index of the data bit being sent or taken.
    typedef logic [$clog2(uart_cfg_pkg::DATA_BITS)-1:0] bit_idx_t;

    // clk count inside one oversample tick.
    typedef logic [$clog2(uart_cfg_pkg::CLKS_PER_TICK)-1:0] div_cnt_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    div_cnt_t div_cnt;

    // tick is registered, so it lands on the clock after the counter wraps.
    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == div_cnt_t'(CLKS_PER_TICK - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       tick,
    input  logic                       start_n,
    input  uart_types_pkg::uart_byte_t data,
    output logic                       tx,
    output logic                       ready_to_send
);
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    logic [1:0] start_hist;
    logic       start_fall;
    logic       armed;
    logic       frame_go;
    logic       bit_done;
    tx_state_t  state;
    tick_cnt_t  tick_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_reg;

    assign start_fall = start_hist[1] & ~start_hist[0];
    assign frame_go   = tick && (state == tx_idle) && armed;
    assign bit_done   = tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));

    // a falling strobe seen while busy is dropped.
    always_ff @(posedge clk) begin
        if (!rst) begin
            start_hist <= 2'b11;
            armed      <= 1'b0;
        end else begin
            start_hist <= {start_hist[0], start_n};
            if (frame_go) begin
                armed <= 1'b0;
            end else if (start_fall && ready_to_send) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= tx_idle;
            tick_cnt      <= '0;
            bit_idx       <= '0;
            tx            <= 1'b1;
            ready_to_send <= 1'b1;
        end else if (tick) begin
            case (state)
                tx_idle: begin
                    if (armed) begin
                        state         <= tx_start;
                        tick_cnt      <= '0;
                        tx            <= 1'b0;
                        ready_to_send <= 1'b0;
                    end
                end
                tx_start: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (bit_done) begin
                        state   <= tx_data;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                    end
                end
                tx_data: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (bit_done) begin
                        if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
                            state <= tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end
                end
                tx_stop: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (bit_done) begin
                        state         <= tx_idle;
                        ready_to_send <= 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // byte is taken as the start bit goes out; LSB leaves first.
    always_ff @(posedge clk) begin
        if (frame_go) begin
            shift_reg <= data;
        end else if (bit_done && (state == tx_start || state == tx_data)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // the line never leaves mark while the transmitter reports idle.
    assert property (@(posedge clk) disable iff (!rst)
        ready_to_send |-> tx)
        else $error("uart_tx: tx low while ready_to_send is high");

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       tick,
    input  logic                       rx,
    output uart_types_pkg::uart_byte_t data,
    output logic                       valid,
    output logic                       frame_error
);
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    logic       rx_meta;
    logic       rx_sync;
    logic       wait_high;
    logic       half_done;
    logic       bit_done;
    rx_state_t  state;
    tick_cnt_t  tick_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_reg;

    assign half_done = tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE / 2 - 1));
    assign bit_done  = tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));

    // line idles high, so the synchronizer resets to mark.
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= rx_idle;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            wait_high   <= 1'b0;
            valid       <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            valid       <= 1'b0;
            frame_error <= 1'b0;
            if (rx_sync) begin
                wait_high <= 1'b0;
            end
            case (state)
                rx_idle: begin
                    if (tick && !rx_sync && !wait_high) begin
                        state    <= rx_start;
                        tick_cnt <= '0;
                    end
                end
                rx_start: begin
                    // half a bit in, the start bit must still be low.
                    if (half_done) begin
                        if (rx_sync) begin
                            state <= rx_idle;
                        end else begin
                            state    <= rx_data;
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_done) begin
                        if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                rx_stop: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_done) begin
                        state <= rx_idle;
                        if (rx_sync) begin
                            valid <= 1'b1;
                        end else begin
                            // a break or bad frame must end before we rearm.
                            frame_error <= 1'b1;
                            wait_high   <= 1'b1;
                        end
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // samples come in LSB first at bit centres.
    always_ff @(posedge clk) begin
        if (bit_done && state == rx_data) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (bit_done && state == rx_stop && rx_sync) begin
            data <= shift_reg;
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        !(valid && frame_error))
        else $error("uart_rx: valid and frame_error together");

    // one report per frame, never stretched.
    assert property (@(posedge clk) disable iff (!rst)
        (valid || frame_error) |=> !(valid || frame_error))
        else $error("uart_rx: report pulse longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_n,
    input  uart_types_pkg::uart_byte_t tx_data,
    output logic                       tx_line,
    output logic                       ready_to_send,
    input  logic                       rx_line,
    output uart_types_pkg::uart_byte_t rx_data,
    output logic                       rx_valid,
    output logic                       frame_error
);

    // shared oversample tick.
    logic tick;

    uart_baud_gen baud_gen0 (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_tx tx0 (
        .clk           (clk),
        .rst           (rst),
        .tick          (tick),
        .start_n       (start_n),
        .data          (tx_data),
        .tx            (tx_line),
        .ready_to_send (ready_to_send)
    );

    uart_rx rx0 (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .rx          (rx_line),
        .data        (rx_data),
        .valid       (rx_valid),
        .frame_error (frame_error)
    );

endmodule

`default_nettype wire

//--- testbench/tb_uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link;
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int BIT_CLKS    = CLKS_PER_TICK * OVERSAMPLE;
    localparam int WATCHDOG_NS = 40 * CLKS_PER_FRAME * CLK_PERIOD + 20000;

    logic       clk;
    logic       rst;
    logic       start_n;
    uart_byte_t tx_data;
    logic       tx_line;
    logic       ready_to_send;
    logic       rx_line;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       frame_error;

    // rx_line comes either from tx_line or from tb_rx.
    logic       use_loop;
    logic       tb_rx;

    uart_byte_t exp_q[$];
    int         seed;
    int         accepted_starts;
    int         valid_count;
    int         ferr_count;
    int         frames_checked;
    int         stim_errs;
    int         line_errs;
    int         rx_errs;
    int         loop_ferr_errs;
    int         drive_valid_errs;
    int         busy_errs;
    int         tests_passed;
    int         tests_failed;

    assign rx_line = use_loop ? tx_line : tb_rx;

    uart_link dut0 (
        .clk           (clk),
        .rst           (rst),
        .start_n       (start_n),
        .tx_data       (tx_data),
        .tx_line       (tx_line),
        .ready_to_send (ready_to_send),
        .rx_line       (rx_line),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .frame_error   (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // a looped-back frame is always well formed.
    assert property (@(posedge clk) disable iff (!rst) use_loop |-> !frame_error)
        else begin
            $display("Error at %0t ns: frame_error is 1, expected 0 in loopback", $time);
            loop_ferr_errs++;
        end

    assert property (@(posedge clk) disable iff (!rst) !use_loop |-> !rx_valid)
        else begin
            $display("Error at %0t ns: rx_valid is 1, expected 0 on a driven bad frame", $time);
            drive_valid_errs++;
        end

    // busy and the start bit begin on the same clock.
    assert property (@(posedge clk) disable iff (!rst) $fell(ready_to_send) |-> $fell(tx_line))
        else begin
            $display("Error at %0t ns: ready_to_send fell without the start bit", $time);
            busy_errs++;
        end

    function automatic int total_errors();
        return stim_errs + line_errs + rx_errs + loop_ferr_errs + drive_valid_errs + busy_errs;
    endfunction

    initial begin : rx_checker
        forever begin
            @(negedge clk);
            if (rst && rx_valid) begin
                valid_count++;
                if (exp_q.size() == 0) begin
                    $display("rx checker: rx_valid pulsed at %0t ns with no byte sent", $time);
                    rx_errs++;
                end else begin
                    assert (rx_data === exp_q[0]) else begin
                        $display("Error at %0t ns: rx_data is %h, expected %h",
                                 $time, rx_data, exp_q[0]);
                        rx_errs++;
                    end
                    exp_q.delete(0);
                end
            end
            if (rst && frame_error) begin
                ferr_count++;
            end
        end
    end

    // samples tx_line near the middle of every bit of each frame.
    initial begin : line_monitor
        uart_byte_t frame_byte;
        logic [9:0] frame_bits;
        time        t_fall;
        int         elapsed;
        int         i;
        forever begin
            @(negedge tx_line);
            t_fall = $time;
            frame_byte = '0;
            if (exp_q.size() == 0) begin
                $display("line monitor: frame started at %0t ns with no byte sent", $time);
                line_errs++;
            end else begin
                frame_byte = exp_q[$];
            end
            frame_bits = {1'b1, frame_byte, 1'b0};
            repeat (BIT_CLKS / 2) @(negedge clk);
            for (i = 0; i < 10; i++) begin
                if (i > 0) begin
                    repeat (BIT_CLKS) @(negedge clk);
                end
                assert (tx_line === frame_bits[i]) else begin
                    $display("Error at %0t ns: tx_line is %b, expected %b in bit %0d",
                             $time, tx_line, frame_bits[i], i);
                    line_errs++;
                end
                assert (ready_to_send === 1'b0) else begin
                    $display("Error at %0t ns: ready_to_send is %b, expected 0",
                             $time, ready_to_send);
                    line_errs++;
                end
            end
            @(posedge ready_to_send);
            elapsed = int'($time - t_fall);
            assert (elapsed == CLKS_PER_FRAME * CLK_PERIOD) else begin
                $display("Error at %0t ns: ready_to_send rise delay is %0d ns, expected %0d ns",
                         $time, elapsed, CLKS_PER_FRAME * CLK_PERIOD);
                line_errs++;
            end
            frames_checked++;
        end
    end

    // caller is one ns past a rising edge.
    task automatic pulse_start_n();
        start_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        start_n = 1'b1;
    endtask

    task automatic send_byte(input uart_byte_t value);
        while (!ready_to_send) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        tx_data = value;
        exp_q.push_back(value);
        accepted_starts++;
        pulse_start_n();
        while (ready_to_send) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_link_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        while (!ready_to_send) begin
            @(negedge clk);
        end
    endtask

    task automatic drive_line_frame(input uart_byte_t value, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            tb_rx = bits[i];
            repeat (BIT_CLKS) @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin : stimulus
        int errs0;
        int v0;
        int s0;
        int f0;
        int rnd;
        int n;
        rst      = 1'b0;
        start_n  = 1'b1;
        tx_data  = '0;
        tb_rx    = 1'b1;
        use_loop = 1'b1;
        seed     = 32'hb9448d77;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        errs0 = total_errors();
        @(negedge clk);
        assert (tx_line === 1'b1) else begin
            $display("Error at %0t ns: tx_line is %b, expected 1", $time, tx_line);
            stim_errs++;
        end
        assert (ready_to_send === 1'b1) else begin
            $display("Error at %0t ns: ready_to_send is %b, expected 1", $time, ready_to_send);
            stim_errs++;
        end
        for (n = 0; n < 100; n++) begin
            @(negedge clk);
            assert (rx_valid === 1'b0 && frame_error === 1'b0) else begin
                $display("Error at %0t ns: rx_valid/frame_error is %b%b, expected 00",
                         $time, rx_valid, frame_error);
                stim_errs++;
            end
        end
        end_test("reset_levels", errs0);

        errs0 = total_errors();
        for (n = 0; n < 20; n++) begin
            rnd = $random(seed);
            send_byte(rnd[7:0]);
        end
        wait_link_idle();
        end_test("random_loopback", errs0);

        errs0 = total_errors();
        f0 = frames_checked;
        send_byte(8'h55);
        send_byte(8'h01);
        wait_link_idle();
        assert (frames_checked - f0 == 2) else begin
            $display("Error at %0t ns: frames checked is %0d, expected 2",
                     $time, frames_checked - f0);
            stim_errs++;
        end
        end_test("line_format", errs0);

        // extra strobes fall mid-frame, with the data already changed.
        errs0 = total_errors();
        v0 = valid_count;
        s0 = accepted_starts;
        send_byte(8'h3C);
        repeat (BIT_CLKS * 2) @(posedge clk);
        #1;
        tx_data = 8'hC3;
        pulse_start_n();
        repeat (BIT_CLKS * 3) @(posedge clk);
        #1;
        pulse_start_n();
        wait_link_idle();
        repeat (CLKS_PER_FRAME) @(negedge clk);
        assert (ready_to_send === 1'b1) else begin
            $display("start while busy: an ignored strobe launched another frame");
            stim_errs++;
        end
        assert (valid_count - v0 == accepted_starts - s0) else begin
            $display("Error at %0t ns: rx_valid count is %0d, expected %0d",
                     $time, valid_count - v0, accepted_starts - s0);
            stim_errs++;
        end
        end_test("start_while_busy", errs0);

        errs0 = total_errors();
        v0 = valid_count;
        f0 = ferr_count;
        @(posedge clk);
        #1;
        use_loop = 1'b0;
        tb_rx = 1'b1;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
        drive_line_frame(8'hA5, 1'b0);
        tb_rx = 1'b1;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
        assert (ferr_count - f0 == 1) else begin
            $display("Error at %0t ns: frame_error count is %0d, expected 1",
                     $time, ferr_count - f0);
            stim_errs++;
        end
        use_loop = 1'b1;
        send_byte(8'h5A);
        wait_link_idle();
        assert (valid_count - v0 == 1) else begin
            $display("Error at %0t ns: rx_valid count is %0d, expected 1",
                     $time, valid_count - v0);
            stim_errs++;
        end
        end_test("frame_error", errs0);

        errs0 = total_errors();
        send_byte(8'h00);
        send_byte(8'hFF);
        send_byte(8'h80);
        wait_link_idle();
        end_test("edge_bytes", errs0);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_link.f
verilog/uart_cfg_pkg.sv
verilog/uart_types_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_link.sv
testbench/tb_uart_link.sv

//--- run.sh
#!/bin/sh
# Builds the uart_link testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart_link -f uart_link.f
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_uart_link 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "run.sh: pass message not found"
exit 1
